//--- include/debug_macros.svh
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

// mips datapath widths
`define DBG_WORD_W      32
`define DBG_REG_IDX_W   5
`define DBG_NUM_REGS    32

// dump frame is 32 registers plus 100 bytes of stage values
`define DBG_FRAME_BYTES 228

// pc+4 value of the last instruction slot in program memory
`define DBG_PROGRAM_END_PC 508

`endif

//--- verilog/dbg_pipe_pkg.sv
`default_nettype none

`include "debug_macros.svh"

package dbg_pipe_pkg;

	typedef logic [`DBG_WORD_W-1:0]    word_t;
	typedef logic [`DBG_REG_IDX_W-1:0] reg_idx_t;

	// entry i is register i
	typedef word_t [`DBG_NUM_REGS-1:0] reg_file_t;

	//////////////////////////////////////////////////////////////////////
	// per-stage snapshots, fields in frame order
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		word_t pc;
		word_t instruction;
	} if_snap_t;

	typedef struct packed {
		word_t    pc_plus4;
		word_t    instruction;
		word_t    write_data;
		reg_idx_t write_addr;
		// alu result forwarded back from ex
		word_t    alu_result_fwd;
		word_t    reg_data1;
		word_t    reg_data2;
		word_t    sign_ext;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		word_t    pc_jump;
		word_t    pc_branch;
	} id_snap_t;

	typedef struct packed {
		word_t    pc_plus4;
		word_t    reg_data1;
		word_t    reg_data2;
		word_t    sign_ext;
		reg_idx_t rt;
		reg_idx_t rd;
		logic     zero;
		word_t    alu_result;
		word_t    reg_data2_out;
		// rt or rd, whichever the mux picked
		reg_idx_t dest_reg;
	} ex_snap_t;

	typedef struct packed {
		word_t address;
		word_t write_data;
		word_t read_data;
	} mem_snap_t;

	typedef struct packed {
		word_t mem_data;
		word_t alu_result;
		word_t write_data;
	} wb_snap_t;

	typedef struct packed {
		if_snap_t  if_stage;
		id_snap_t  id_stage;
		ex_snap_t  ex_stage;
		mem_snap_t mem_stage;
		wb_snap_t  wb_stage;
	} pipe_snap_t;

endpackage

`default_nettype wire

//--- verilog/dbg_ctrl_pkg.sv
`default_nettype none

package dbg_ctrl_pkg;

	// command bytes from the host
	typedef enum logic [7:0] {
		cmd_run  = 8'h01,
		cmd_step = 8'h02
	} dbg_cmd_e;

	// pipeline run mode, finished sticks until reset
	typedef enum logic [1:0] {
		mode_halt,
		mode_run,
		mode_step,
		mode_finished
	} run_mode_e;

	// dump sequencer
	typedef enum logic [2:0] {
		dump_idle,
		dump_settle,
		dump_capture,
		dump_send,
		dump_wait
	} dump_state_e;

endpackage

`default_nettype wire

//--- verilog/dbg_command_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_macros.svh"

module dbg_command_ctrl
	import dbg_pipe_pkg::*;
	import dbg_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_empty,
	input  logic [7:0] r_data,
	input  word_t      pc_plus4,
	output logic       rd_uart,
	output logic       ena_pip
);

	logic      pop_req;
	logic      mode_active;
	logic      program_end;
	run_mode_e mode;

	// a byte is waiting and the last cycle was not a pop
	assign pop_req = ~rx_empty & ~rd_uart;

	assign mode_active = (mode == mode_run) || (mode == mode_step);
	assign program_end = (pc_plus4 == `DBG_PROGRAM_END_PC);

	function automatic run_mode_e decode_cmd(input logic [7:0] cmd);
		run_mode_e next_mode;
		case (cmd)
			cmd_step: next_mode = mode_step;
			cmd_run:  next_mode = mode_run;
			default:  next_mode = mode_halt;
		endcase
		return next_mode;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// pop pulse, mode and pipeline enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_uart <= 1'b0;
			mode    <= mode_halt;
			ena_pip <= 1'b0;
		end
		else
		begin
			rd_uart <= pop_req;
			if (pop_req)
			begin
				// pending byte wins over end detection this cycle
				ena_pip <= mode_active;
				if (mode != mode_finished)
					mode <= decode_cmd(r_data);
			end
			else if (program_end)
			begin
				mode    <= mode_finished;
				ena_pip <= 1'b0;
			end
			else
			begin
				ena_pip <= mode_active;
				// single step consumed, back to halt
				if (mode == mode_step)
					mode <= mode_halt;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/dbg_snapshot_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_macros.svh"

module dbg_snapshot_capture
	import dbg_pipe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       capture,
	input  reg_file_t  regs,
	input  pipe_snap_t snap,
	input  logic [7:0] byte_idx,
	output logic [7:0] frame_byte
);

	reg_file_t  regs_q;
	pipe_snap_t snap_q;

	// register 0 first
	word_t [0:`DBG_NUM_REGS-1] reg_seq;

	// byte 0 of the frame sits at the top
	logic [0:`DBG_FRAME_BYTES-1][7:0] frame;

	function automatic logic [7:0] idx_byte(input reg_idx_t idx);
		return 8'(idx);
	endfunction

	// frozen at capture so the whole frame is one moment
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			regs_q <= '0;
			snap_q <= '0;
		end
		else if (capture)
		begin
			regs_q <= regs;
			snap_q <= snap;
		end
	end

	always_comb
	begin
		for (int i = 0; i < `DBG_NUM_REGS; i++)
			reg_seq[i] = regs_q[i];
	end

	//////////////////////////////////////////////////////////////////////
	// frame layout, words msb first, indices and flag as one byte
	//////////////////////////////////////////////////////////////////////

	assign frame = {
		reg_seq,
		// if
		snap_q.if_stage.pc,
		snap_q.if_stage.instruction,
		// id
		snap_q.id_stage.pc_plus4,
		snap_q.id_stage.instruction,
		snap_q.id_stage.write_data,
		idx_byte(snap_q.id_stage.write_addr),
		snap_q.id_stage.alu_result_fwd,
		snap_q.id_stage.reg_data1,
		snap_q.id_stage.reg_data2,
		snap_q.id_stage.sign_ext,
		idx_byte(snap_q.id_stage.rs),
		idx_byte(snap_q.id_stage.rt),
		idx_byte(snap_q.id_stage.rd),
		snap_q.id_stage.pc_jump,
		snap_q.id_stage.pc_branch,
		// ex
		snap_q.ex_stage.pc_plus4,
		snap_q.ex_stage.reg_data1,
		snap_q.ex_stage.reg_data2,
		snap_q.ex_stage.sign_ext,
		idx_byte(snap_q.ex_stage.rt),
		idx_byte(snap_q.ex_stage.rd),
		{7'b0, snap_q.ex_stage.zero},
		snap_q.ex_stage.alu_result,
		snap_q.ex_stage.reg_data2_out,
		idx_byte(snap_q.ex_stage.dest_reg),
		// mem
		snap_q.mem_stage.address,
		snap_q.mem_stage.write_data,
		snap_q.mem_stage.read_data,
		// wb
		snap_q.wb_stage.mem_data,
		snap_q.wb_stage.alu_result,
		snap_q.wb_stage.write_data
	};

	assign frame_byte = frame[byte_idx];

endmodule

`default_nettype wire

//--- verilog/dbg_dump_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_macros.svh"

module dbg_dump_tx
	import dbg_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       dump_req,
	input  logic       tx_done_tick,
	input  logic [7:0] frame_byte,
	output logic       capture,
	output logic [7:0] byte_idx,
	output logic       wr_uart,
	output logic [7:0] w_data
);

	dump_state_e state;
	logic [7:0]  byte_cnt;
	logic        last_byte;

	assign last_byte = (byte_cnt == 8'(`DBG_FRAME_BYTES - 1));
	assign capture   = (state == dump_capture);
	assign byte_idx  = byte_cnt;

	//////////////////////////////////////////////////////////////////////
	// dump sequencer, one byte per tx done tick
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= dump_idle;
			byte_cnt <= '0;
			wr_uart  <= 1'b0;
		end
		else
		begin
			wr_uart <= 1'b0;
			case (state)
				dump_idle:
				begin
					// pops while busy are ignored here
					if (dump_req)
						state <= dump_settle;
				end
				dump_settle:
					state <= dump_capture;
				dump_capture:
				begin
					byte_cnt <= '0;
					state    <= dump_send;
				end
				dump_send:
				begin
					wr_uart <= 1'b1;
					state   <= dump_wait;
				end
				dump_wait:
				begin
					// hold until the transmitter finishes this byte
					if (tx_done_tick)
					begin
						if (last_byte)
							state <= dump_idle;
						else
						begin
							byte_cnt <= byte_cnt + 8'd1;
							state    <= dump_send;
						end
					end
				end
				default:
					state <= dump_idle;
			endcase
		end
	end

	// byte goes out with the send pulse
	always_ff @(posedge clk)
	begin
		if (state == dump_send)
			w_data <= frame_byte;
	end

endmodule

`default_nettype wire

//--- verilog/debug_unit.sv
`timescale 1ns/100ps
`default_nettype none

module debug_unit
	import dbg_pipe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	// receive fifo
	input  logic       rx_empty,
	input  logic [7:0] r_data,
	output logic       rd_uart,
	// transmitter
	input  logic       tx_done_tick,
	output logic       wr_uart,
	output logic [7:0] w_data,
	// pipeline
	input  word_t      pc_plus4,
	input  reg_file_t  regs,
	input  pipe_snap_t snap,
	output logic       ena_pip
);

	logic       capture;
	logic [7:0] byte_idx;
	logic [7:0] frame_byte;

	//////////////////////////////////////////////////////////////////////
	// command side
	//////////////////////////////////////////////////////////////////////

	dbg_command_ctrl u_command_ctrl (
		.clk      (clk),
		.reset    (reset),
		.rx_empty (rx_empty),
		.r_data   (r_data),
		.pc_plus4 (pc_plus4),
		.rd_uart  (rd_uart),
		.ena_pip  (ena_pip)
	);

	//////////////////////////////////////////////////////////////////////
	// dump side, every pop requests a frame
	//////////////////////////////////////////////////////////////////////

	dbg_dump_tx u_dump_tx (
		.clk          (clk),
		.reset        (reset),
		.dump_req     (rd_uart),
		.tx_done_tick (tx_done_tick),
		.frame_byte   (frame_byte),
		.capture      (capture),
		.byte_idx     (byte_idx),
		.wr_uart      (wr_uart),
		.w_data       (w_data)
	);

	dbg_snapshot_capture u_snapshot_capture (
		.clk        (clk),
		.reset      (reset),
		.capture    (capture),
		.regs       (regs),
		.snap       (snap),
		.byte_idx   (byte_idx),
		.frame_byte (frame_byte)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/debug_unit_checker.sv
`timescale 1ns/100ps
`default_nettype none

module debug_unit_checker
(
	input logic clk,
	input logic reset,
	input logic rx_empty,
	input logic rd_uart,
	input logic wr_uart,
	input logic ena_pip
);

	//////////////////////////////////////////////////////////////////////
	// strobe rules on the uart side
	//////////////////////////////////////////////////////////////////////

	// pop is a single cycle pulse
	rd_single: assert property (@(posedge clk) disable iff (reset)
		rd_uart |=> !rd_uart)
		else $error("rd_uart high for two cycles in a row");

	// only pop when the fifo had data one cycle earlier
	rd_needs_data: assert property (@(posedge clk) disable iff (reset)
		rd_uart |-> $past(!rx_empty))
		else $error("rd_uart high without a byte in the fifo");

	wr_single: assert property (@(posedge clk) disable iff (reset)
		wr_uart |=> !wr_uart)
		else $error("wr_uart high for two cycles in a row");

	// all outputs quiet while reset is held
	quiet_in_reset: assert property (@(posedge clk)
		reset |-> (!ena_pip && !rd_uart && !wr_uart))
		else $error("output active during reset");

endmodule

`default_nettype wire

//--- tests/debug_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_macros.svh"

module debug_unit_tb
	import dbg_pipe_pkg::*;
;

	logic       clk;
	logic       reset;
	logic       rx_empty;
	logic [7:0] r_data;
	logic       rd_uart;
	logic       tx_done_tick;
	logic       wr_uart;
	logic [7:0] w_data;
	word_t      pc_plus4;
	reg_file_t  regs;
	pipe_snap_t snap;
	logic       ena_pip;

	logic [7:0] fifo_q[$];
	logic [7:0] rx_frame[$];
	logic [7:0] exp_q[$];
	int         tx_wait;
	int         sent_count;
	reg_file_t  cmd_regs;
	pipe_snap_t cmd_snap;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	debug_unit dut (
		.clk          (clk),
		.reset        (reset),
		.rx_empty     (rx_empty),
		.r_data       (r_data),
		.rd_uart      (rd_uart),
		.tx_done_tick (tx_done_tick),
		.wr_uart      (wr_uart),
		.w_data       (w_data),
		.pc_plus4     (pc_plus4),
		.regs         (regs),
		.snap         (snap),
		.ena_pip      (ena_pip)
	);

	bind debug_unit debug_unit_checker u_checker (
		.clk      (clk),
		.reset    (reset),
		.rx_empty (rx_empty),
		.rd_uart  (rd_uart),
		.wr_uart  (wr_uart),
		.ena_pip  (ena_pip)
	);

	//////////////////////////////////////////////////////////////////////
	// uart side models
	//////////////////////////////////////////////////////////////////////

	// receive fifo shows its front byte while not empty
	always
	begin
		@(posedge clk);
		#1;
		if (rd_uart && fifo_q.size() > 0)
			void'(fifo_q.pop_front());
		rx_empty = (fifo_q.size() == 0);
		r_data   = (fifo_q.size() == 0) ? 8'h00 : fifo_q[0];
	end

	// transmitter pulses done 4 cycles after each send
	always
	begin
		@(posedge clk);
		#1;
		tx_done_tick = 1'b0;
		if (tx_wait > 0)
		begin
			tx_wait = tx_wait - 1;
			if (tx_wait == 0)
				tx_done_tick = 1'b1;
		end
		if (wr_uart)
		begin
			rx_frame.push_back(w_data);
			tx_wait    = 4;
			sent_count = sent_count + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic fail_stop(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped on first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			fail_stop($sformatf("Mismatch at %0t: %s, got %0h expected %0h",
				$time, msg, actual, expected));
		end
	endtask

	task automatic scramble_inputs();
		logic [$bits(pipe_snap_t)-1:0] bits_v;
		for (int i = 0; i < `DBG_NUM_REGS; i++)
			regs[i] = $urandom;
		for (int j = 0; j < $bits(pipe_snap_t); j++)
			bits_v[j] = 1'($urandom);
		snap = pipe_snap_t'(bits_v);
	endtask

	task automatic push_word(input word_t w);
		for (int b = 3; b >= 0; b--)
			exp_q.push_back(w[b*8 +: 8]);
	endtask

	task automatic push_idx(input reg_idx_t idx);
		exp_q.push_back({3'b000, idx});
	endtask

	// frame from the values held at command time
	task automatic build_expected();
		exp_q.delete();
		for (int i = 0; i < `DBG_NUM_REGS; i++)
			push_word(cmd_regs[i]);
		push_word(cmd_snap.if_stage.pc);
		push_word(cmd_snap.if_stage.instruction);
		push_word(cmd_snap.id_stage.pc_plus4);
		push_word(cmd_snap.id_stage.instruction);
		push_word(cmd_snap.id_stage.write_data);
		push_idx(cmd_snap.id_stage.write_addr);
		push_word(cmd_snap.id_stage.alu_result_fwd);
		push_word(cmd_snap.id_stage.reg_data1);
		push_word(cmd_snap.id_stage.reg_data2);
		push_word(cmd_snap.id_stage.sign_ext);
		push_idx(cmd_snap.id_stage.rs);
		push_idx(cmd_snap.id_stage.rt);
		push_idx(cmd_snap.id_stage.rd);
		push_word(cmd_snap.id_stage.pc_jump);
		push_word(cmd_snap.id_stage.pc_branch);
		push_word(cmd_snap.ex_stage.pc_plus4);
		push_word(cmd_snap.ex_stage.reg_data1);
		push_word(cmd_snap.ex_stage.reg_data2);
		push_word(cmd_snap.ex_stage.sign_ext);
		push_idx(cmd_snap.ex_stage.rt);
		push_idx(cmd_snap.ex_stage.rd);
		exp_q.push_back({7'b0, cmd_snap.ex_stage.zero});
		push_word(cmd_snap.ex_stage.alu_result);
		push_word(cmd_snap.ex_stage.reg_data2_out);
		push_idx(cmd_snap.ex_stage.dest_reg);
		push_word(cmd_snap.mem_stage.address);
		push_word(cmd_snap.mem_stage.write_data);
		push_word(cmd_snap.mem_stage.read_data);
		push_word(cmd_snap.wb_stage.mem_data);
		push_word(cmd_snap.wb_stage.alu_result);
		push_word(cmd_snap.wb_stage.write_data);
	endtask

	// queue a byte and check the enable one cycle after its pop
	task automatic run_command(input logic [7:0] cmd, input logic ena_after);
		int cycles;
		cmd_regs = regs;
		cmd_snap = snap;
		rx_frame.delete();
		fifo_q.push_back(cmd);
		cycles = 0;
		do
		begin
			tick();
			cycles++;
			if (cycles > 50)
				fail_stop($sformatf("command %0h was never popped", cmd));
		end
		while (!rd_uart);
		tick();
		check_value(32'(ena_pip), 32'(ena_after), "ena_pip after pop");
	endtask

	// gather one frame and optionally check the enable every cycle
	task automatic collect_frame(input bit check_ena, input logic ena_exp, input bit scramble);
		int  cycles;
		bit  scrambled;
		cycles    = 0;
		scrambled = 1'b0;
		while (rx_frame.size() < `DBG_FRAME_BYTES || tx_wait > 0)
		begin
			tick();
			cycles++;
			if (cycles > 4000)
				fail_stop("dump frame did not complete in time");
			if (check_ena)
				check_value(32'(ena_pip), 32'(ena_exp), "ena_pip during dump");
			if (scramble && !scrambled && rx_frame.size() > 0)
			begin
				scramble_inputs();
				pc_plus4  = {$urandom} & 32'h0000_00fc;
				scrambled = 1'b1;
			end
		end
		repeat (3) tick();
		build_expected();
		check_value(32'(rx_frame.size()), 32'(`DBG_FRAME_BYTES), "frame length");
		for (int i = 0; i < `DBG_FRAME_BYTES; i++)
			check_value(32'(rx_frame[i]), 32'(exp_q[i]), $sformatf("frame byte %0d", i));
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		for (int i = 0; i < 20; i++)
		begin
			check_value(32'(ena_pip), 32'd0, "ena_pip idle");
			check_value(32'(rd_uart), 32'd0, "rd_uart idle");
			check_value(32'(wr_uart), 32'd0, "wr_uart idle");
			tick();
		end
		check_value(32'(sent_count), 32'd0, "bytes sent with empty fifo");
	endtask

	task automatic step_command();
		scramble_inputs();
		run_command(8'h02, 1'b1);
		tick();
		check_value(32'(ena_pip), 32'd0, "ena_pip after single step");
		collect_frame(1'b1, 1'b0, 1'b0);
	endtask

	task automatic run_then_halt();
		scramble_inputs();
		run_command(8'h01, 1'b1);
		collect_frame(1'b1, 1'b1, 1'b0);
		scramble_inputs();
		run_command(8'h00, 1'b0);
		collect_frame(1'b1, 1'b0, 1'b0);
	endtask

	task automatic frozen_snapshot();
		scramble_inputs();
		run_command(8'h02, 1'b1);
		collect_frame(1'b0, 1'b0, 1'b1);
	endtask

	task automatic program_finish();
		pc_plus4 = 32'h0000_0040;
		scramble_inputs();
		run_command(8'h01, 1'b1);
		collect_frame(1'b1, 1'b1, 1'b0);
		check_value(32'(ena_pip), 32'd1, "ena_pip before program end");
		pc_plus4 = `DBG_PROGRAM_END_PC;
		tick();
		check_value(32'(ena_pip), 32'd0, "ena_pip at program end");
		// finished mode holds without the end pc
		pc_plus4 = 32'h0000_0040;
		for (int i = 0; i < 10; i++)
		begin
			tick();
			check_value(32'(ena_pip), 32'd0, "ena_pip after finish");
		end
		scramble_inputs();
		run_command(8'h01, 1'b0);
		collect_frame(1'b1, 1'b0, 1'b0);
	endtask

	initial
	begin
		int cycles;
		rx_empty     = 1'b1;
		r_data       = 8'h00;
		tx_done_tick = 1'b0;
		pc_plus4     = '0;
		regs         = '0;
		snap         = '0;
		tx_wait      = 0;
		sent_count   = 0;
		void'($urandom(32'hf7c45488));

		cycles = 0;
		while (reset !== 1'b0)
		begin
			tick();
			cycles++;
			if (cycles > 20)
				fail_stop("reset was never released");
		end

		idle_after_reset();
		step_command();
		run_then_halt();
		frozen_snapshot();
		program_finish();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
verilog/dbg_pipe_pkg.sv
verilog/dbg_ctrl_pkg.sv
verilog/dbg_command_ctrl.sv
verilog/dbg_snapshot_capture.sv
verilog/dbg_dump_tx.sv
verilog/debug_unit.sv
tests/tb_clock_gen.sv
tests/debug_unit_checker.sv
tests/debug_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the debug unit testbench with verilator
rm -f sim.log
verilator --binary --timing --assert --top-module debug_unit_tb -f sources.f \
	&& ./obj_dir/Vdebug_unit_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
